//--- Makefile
VERILATOR ?= verilator
TOP ?= i2s_capture_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ps -Wno-fatal
FAIL_MSG ?= Something failed
PASS_MSG ?= Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST))
STIM := verification/i2s_capture_stimulus.txt

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) source/i2s_capture_config.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP) $(STIM)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+source
source/i2s_capture_pkg.sv
source/payload_if.sv
source/i2s_deserializer.sv
source/frame_extractor.sv
source/lane_merge_fifo.sv
source/i2s_capture_top.sv
verification/tb_clock_gen.sv
verification/i2s_capture_tb.sv

//--- source/frame_extractor.sv
`default_nettype none
`include "i2s_capture_config.svh"

module frame_extractor
	import i2s_capture_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic sample_valid,
	input sample_t sample,
	payload_if.lane lane
);

	localparam int HDR_W = `HEADER_BYTES * 8;
	localparam int PAY_W = `PAYLOAD_BYTES * 8;
	localparam int CNT_W = $clog2(`FRAME_BYTES + 1);
	localparam int SEND_W = $clog2(`PAYLOAD_BYTES + 1);

	logic [HDR_W-1:0] win_q;
	logic [HDR_W-1:0] win_next;
	logic in_frame;
	logic [CNT_W-1:0] byte_cnt;
	logic frame_done;
	logic [PAY_W-1:0] stored_q;
	logic [PAY_W-1:0] send_buf;
	logic [SEND_W-1:0] send_cnt;

	// high byte of the sample is the earlier one
	assign win_next = {win_q[HDR_W-17:0], sample};
	assign frame_done = sample_valid && in_frame && byte_cnt == CNT_W'(`FRAME_BYTES - 2);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// header search and frame count
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			win_q <= '0;
			in_frame <= 1'b0;
			byte_cnt <= '0;
			stored_q <= '0;
			lane.pending <= 1'b0;
			send_cnt <= '0;
		end else begin
			if (sample_valid) begin
				win_q <= win_next;
				if (!in_frame) begin
					if (win_next == `I2S_HEADER) begin
						in_frame <= 1'b1;
						byte_cnt <= CNT_W'(`HEADER_BYTES);
					end
				end else if (frame_done) begin
					in_frame <= 1'b0;
				end else begin
					byte_cnt <= byte_cnt + CNT_W'(2);
				end
			end

			if (send_cnt != '0) begin
				send_cnt <= send_cnt - 1'b1;
			end
			if (lane.grant) begin
				lane.pending <= 1'b0;
				send_cnt <= SEND_W'(`PAYLOAD_BYTES);
			end

			// payload is the tail of the window, a new one overrides a waiting one
			if (frame_done && win_next[PAY_W-1:0] != stored_q) begin
				stored_q <= win_next[PAY_W-1:0];
				lane.pending <= 1'b1;
			end
		end
	end

	// snapshot on grant so a late frame cannot disturb the stream
	always_ff @(posedge clk) begin
		if (lane.grant) begin
			send_buf <= stored_q;
		end else if (send_cnt != '0) begin
			send_buf <= {send_buf[PAY_W-9:0], 8'h00};
		end
	end

	assign lane.valid = send_cnt != '0;
	assign lane.data = send_buf[PAY_W-1 -: 8];
	assign lane.last = send_cnt == SEND_W'(1);

	a_valid_after_grant: assert property (
		@(posedge clk) disable iff (!rst_n) $rose(lane.valid) |-> $past(lane.grant)
	);

endmodule

`default_nettype wire

//--- source/i2s_capture_config.svh
`ifndef I2S_CAPTURE_CONFIG_SVH
`define I2S_CAPTURE_CONFIG_SVH

// frame sync pattern, first byte in the top bits
`define I2S_HEADER 80'h0B77_A1DD_4240_2F84_2B03

// frame layout in bytes, header included in FRAME_BYTES
`define HEADER_BYTES 10
`define FRAME_BYTES 24
`define PAYLOAD_BYTES 6

// output buffer
`define FIFO_DEPTH 32

// source tags written with every byte
`define LANE0_ID 5'h03
`define LANE1_ID 5'h11

`endif

//--- source/i2s_capture_pkg.sv
`default_nettype none

package i2s_capture_pkg;

	// one byte of the recovered stream
	typedef logic [7:0] byte_t;

	// upper 16 bits of a 24-bit I2S word
	typedef logic [15:0] sample_t;

	typedef logic [4:0] lane_id_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FIFO word, also what the reader sees on rdata
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic [2:0] pad;
		lane_id_t id;
		byte_t data;
	} fifo_entry_t;

endpackage

`default_nettype wire

//--- source/i2s_capture_top.sv
`default_nettype none
`include "i2s_capture_config.svh"

module i2s_capture_top
	import i2s_capture_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic bclk0,
	input logic lrclk0,
	input logic sdata0,
	input logic bclk1,
	input logic lrclk1,
	input logic sdata1,
	input logic r_enable,
	output fifo_entry_t rdata,
	output logic r_ready,
	output logic error_full,
	output logic error_empty
);

	logic sample_valid0;
	logic sample_valid1;
	sample_t sample0;
	sample_t sample1;

	payload_if lane0_if ();
	payload_if lane1_if ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lane 0
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	i2s_deserializer deser0_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bclk(bclk0),
		.lrclk(lrclk0),
		.sdata(sdata0),
		.sample_valid(sample_valid0),
		.sample(sample0)
	);

	frame_extractor extract0_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sample_valid(sample_valid0),
		.sample(sample0),
		.lane(lane0_if.lane)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lane 1
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	i2s_deserializer deser1_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bclk(bclk1),
		.lrclk(lrclk1),
		.sdata(sdata1),
		.sample_valid(sample_valid1),
		.sample(sample1)
	);

	frame_extractor extract1_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sample_valid(sample_valid1),
		.sample(sample1),
		.lane(lane1_if.lane)
	);

	lane_merge_fifo #(
		.LANE0(`LANE0_ID),
		.LANE1(`LANE1_ID)
	) merge_inst (
		.clk(clk),
		.rst_n(rst_n),
		.lane0(lane0_if.merger),
		.lane1(lane1_if.merger),
		.r_enable(r_enable),
		.rdata(rdata),
		.r_ready(r_ready),
		.error_full(error_full),
		.error_empty(error_empty)
	);

endmodule

`default_nettype wire

//--- source/i2s_deserializer.sv
`default_nettype none

module i2s_deserializer
	import i2s_capture_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic bclk,
	input logic lrclk,
	input logic sdata,
	output logic sample_valid,
	output sample_t sample
);

	localparam int WORD_MSB = 23;
	localparam int SAMPLE_LSB = 8;

	logic [1:0] bclk_sync;
	logic [1:0] lrclk_sync;
	logic [1:0] sdata_sync;
	logic bclk_d;
	logic lrclk_d;
	logic bclk_rise;
	logic lr_edge;
	logic [4:0] bit_idx;
	sample_t shift_q;
	logic [1:0] hit_pipe;

	assign bclk_rise = bclk_sync[1] & ~bclk_d;
	assign lr_edge = lrclk_sync[1] != lrclk_d;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sync, bclk edge and bit position
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bclk_sync <= '0;
			lrclk_sync <= '0;
			sdata_sync <= '0;
			bclk_d <= 1'b0;
			lrclk_d <= 1'b0;
			bit_idx <= '0;
			hit_pipe <= '0;
			sample_valid <= 1'b0;
		end else begin
			bclk_sync <= {bclk_sync[0], bclk};
			lrclk_sync <= {lrclk_sync[0], lrclk};
			sdata_sync <= {sdata_sync[0], sdata};
			bclk_d <= bclk_sync[1];
			hit_pipe <= {hit_pipe[0], 1'b0};
			sample_valid <= hit_pipe[1];
			if (bclk_rise) begin
				lrclk_d <= lrclk_sync[1];
				// the edge that sees the new lrclk carries the previous LSB
				if (lr_edge) begin
					bit_idx <= 5'(WORD_MSB);
				end else if (bit_idx != '0) begin
					bit_idx <= bit_idx - 1'b1;
				end
				if (!lr_edge && bit_idx == 5'(SAMPLE_LSB)) begin
					hit_pipe[0] <= 1'b1;
				end
			end
		end
	end

	// word bits 23..8, MSB first
	always_ff @(posedge clk) begin
		if (bclk_rise && !lr_edge && bit_idx >= 5'(SAMPLE_LSB)) begin
			shift_q <= {shift_q[14:0], sdata_sync[1]};
		end
		if (hit_pipe[1]) begin
			sample <= shift_q;
		end
	end

	a_single_strobe: assert property (
		@(posedge clk) disable iff (!rst_n) sample_valid |=> !sample_valid
	);

endmodule

`default_nettype wire

//--- source/lane_merge_fifo.sv
`default_nettype none
`include "i2s_capture_config.svh"

module lane_merge_fifo
	import i2s_capture_pkg::*;
#(
	parameter lane_id_t LANE0 = `LANE0_ID,
	parameter lane_id_t LANE1 = `LANE1_ID
) (
	input logic clk,
	input logic rst_n,
	payload_if.merger lane0,
	payload_if.merger lane1,
	input logic r_enable,
	output fifo_entry_t rdata,
	output logic r_ready,
	output logic error_full,
	output logic error_empty
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

	fifo_entry_t mem [`FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic empty;
	logic room;
	logic busy;
	logic cur_lane;
	logic rr_ptr;
	logic pick;
	logic [1:0] grant_q;
	logic wr_en;
	logic wr_ok;
	logic wr_last;
	logic rd_en;
	fifo_entry_t wr_entry;

	assign full = count == CNT_W'(`FIFO_DEPTH);
	assign empty = count == '0;
	assign room = (CNT_W'(`FIFO_DEPTH) - count) >= CNT_W'(`PAYLOAD_BYTES);

	// rr_ptr breaks the tie only when both wait
	assign pick = (lane0.pending && lane1.pending) ? rr_ptr : lane1.pending;
	assign lane0.grant = grant_q[0];
	assign lane1.grant = grant_q[1];

	assign wr_en = busy && (cur_lane ? lane1.valid : lane0.valid);
	assign wr_ok = wr_en && !full;
	assign wr_last = cur_lane ? lane1.last : lane0.last;
	assign rd_en = r_enable && !empty;
	assign r_ready = !empty;

	always_comb begin
		wr_entry = '0;
		wr_entry.id = cur_lane ? LANE1 : LANE0;
		wr_entry.data = cur_lane ? lane1.data : lane0.data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arbitration, pointers and status
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_q <= '0;
			busy <= 1'b0;
			cur_lane <= 1'b0;
			rr_ptr <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			error_full <= 1'b0;
			error_empty <= 1'b0;
		end else begin
			grant_q <= '0;
			if (!busy && room && (lane0.pending || lane1.pending)) begin
				grant_q[pick] <= 1'b1;
				busy <= 1'b1;
				cur_lane <= pick;
				rr_ptr <= !pick;
			end else if (wr_en && wr_last) begin
				busy <= 1'b0;
			end

			if (wr_ok) begin
				wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// sticky until reset
			if (wr_en && full) begin
				error_full <= 1'b1;
			end
			if (r_enable && empty) begin
				error_empty <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_entry;
		end
		if (rd_en) begin
			rdata <= mem[rd_ptr];
		end
	end

	a_no_write_full: assert property (
		@(posedge clk) disable iff (!rst_n) wr_en |-> !full
	);

endmodule

`default_nettype wire

//--- source/payload_if.sv
`default_nettype none

interface payload_if
	import i2s_capture_pkg::*;
();

	logic pending;
	logic grant;
	logic valid;
	byte_t data;
	logic last;

	// extractor side
	modport lane (output pending, output valid, output data, output last, input grant);

	// merger side
	modport merger (input pending, input valid, input data, input last, output grant);

endinterface

`default_nettype wire

//--- verification/i2s_capture_stimulus.txt
// lane code (0, 1, or 2 for both with lane 1 two clk later), bytes per lane,
// the bytes (lane 0 first), expected entry count, entries as {id, byte}
// lane 0 frame
00 18
0B 77 A1 DD 42 40 2F 84 2B 03
10 11 12 13 14 15 16 17 A1 B2 C3 D4 E5 F6
06 03A1 03B2 03C3 03D4 03E5 03F6
// lane 1 noise, near-miss header, frame body
01 1C
55 AA 3C C3
0B 77 A1 DD 42 40 2F 84 2B 07
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D
00
// lane 1 noise then a real frame
01 1A
9E 61
0B 77 A1 DD 42 40 2F 84 2B 03
30 31 32 33 34 35 36 37 5A 6B 7C 8D 9E AF
06 115A 116B 117C 118D 119E 11AF
// lane 0 repeated payload
00 18
0B 77 A1 DD 42 40 2F 84 2B 03
40 41 42 43 44 45 46 47 A1 B2 C3 D4 E5 F6
00
// lane 0 changed payload
00 18
0B 77 A1 DD 42 40 2F 84 2B 03
50 51 52 53 54 55 56 57 A1 B2 C3 D4 E5 F7
06 03A1 03B2 03C3 03D4 03E5 03F7
// both lanes together
02 18
0B 77 A1 DD 42 40 2F 84 2B 03
60 61 62 63 64 65 66 67 C1 C2 C3 C4 C5 C6
0B 77 A1 DD 42 40 2F 84 2B 03
70 71 72 73 74 75 76 77 D1 D2 D3 D4 D5 D6
0C 03C1 03C2 03C3 03C4 03C5 03C6
11D1 11D2 11D3 11D4 11D5 11D6
// end of records
FF

//--- verification/i2s_capture_tb.sv
`default_nettype none
`include "i2s_capture_config.svh"

module i2s_capture_tb
	import i2s_capture_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int STIM_WORDS = 256;
	localparam logic [15:0] END_MARK = 16'h00ff;
	localparam int SETTLE_CYCLES = 60;

	logic clk;
	logic rst_n;
	logic [1:0] bclk_q;
	logic [1:0] lrclk_q;
	logic [1:0] sdata_q;
	logic r_enable = 1'b0;
	fifo_entry_t rdata;
	logic r_ready;
	logic error_full;
	logic error_empty;

	logic [15:0] stim_mem [STIM_WORDS];
	fifo_entry_t want_q [$];
	fifo_entry_t want_entry;
	fifo_entry_t file_entry;
	logic [1:0] lr_state;
	logic [1:0] prev_lsb;
	logic poke_empty;
	logic ready_seen = 1'b0;
	logic read_issued = 1'b0;
	logic data_read = 1'b0;
	int rand_seed;
	int timeout_limit = 0;
	int cycles = 0;
	int total_bits;
	int rec_idx;
	int cnt_at;
	int k;

	tb_clock_gen clock_gen_inst (
		.clk(clk),
		.rst_n(rst_n)
	);

	i2s_capture_top i2s_capture_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bclk0(bclk_q[0]),
		.lrclk0(lrclk_q[0]),
		.sdata0(sdata_q[0]),
		.bclk1(bclk_q[1]),
		.lrclk1(lrclk_q[1]),
		.sdata1(sdata_q[1]),
		.r_enable(r_enable),
		.rdata(rdata),
		.r_ready(r_ready),
		.error_full(error_full),
		.error_empty(error_empty)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks and failure exit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_entry(input fifo_entry_t got, input fifo_entry_t want);
		if (got !== want) begin
			stop_with_failure($sformatf("FAILED rdata: got 0x%04h, expected 0x%04h", got, want));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			stop_with_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
		end
	endtask

	// each record holds lane code, bytes per lane, bytes, entry count and entries
	function automatic int lanes_of(input int idx);
		return (stim_mem[idx] == 16'h0002) ? 2 : 1;
	endfunction

	function automatic int count_index(input int idx);
		return idx + 2 + lanes_of(idx) * int'(stim_mem[idx + 1]);
	endfunction

	function automatic int next_record(input int idx);
		int at;
		at = count_index(idx);
		return at + 1 + int'(stim_mem[at]);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// I2S serializer with bclk at clk/8
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic drive_bit(input logic l, input logic lr, input logic bit_val);
		@(posedge clk);
		bclk_q[l] <= 1'b0;
		lrclk_q[l] <= lr;
		sdata_q[l] <= bit_val;
		repeat (4) @(posedge clk);
		bclk_q[l] <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic send_lane(input logic l, input int first, input int nbytes);
		logic [23:0] word;
		int pad;
		int w;
		int b;
		for (w = 0; w < nbytes / 2; w++) begin
			pad = $random(rand_seed);
			word = {stim_mem[first + 2 * w][7:0], stim_mem[first + 2 * w + 1][7:0], pad[7:0]};
			lr_state[l] = !lr_state[l];
			// slot after the lrclk change holds the previous word's LSB
			drive_bit(l, lr_state[l], prev_lsb[l]);
			for (b = 23; b >= 1; b--) begin
				drive_bit(l, lr_state[l], word[b]);
			end
			prev_lsb[l] = word[0];
		end
	endtask

	task automatic run_record(input int idx);
		int nbytes;
		int at;
		int n;
		nbytes = int'(stim_mem[idx + 1]);
		at = count_index(idx);
		for (n = 1; n <= int'(stim_mem[at]); n++) begin
			want_q.push_back(fifo_entry_t'(stim_mem[at + n]));
		end
		case (stim_mem[idx])
			16'h0000: send_lane(1'b0, idx + 2, nbytes);
			16'h0001: send_lane(1'b1, idx + 2, nbytes);
			default: begin
				fork
					send_lane(1'b0, idx + 2, nbytes);
					begin
						// lane 1 trails by two clk cycles
						repeat (2) @(posedge clk);
						send_lane(1'b1, idx + 2 + nbytes, nbytes);
					end
				join
			end
		endcase
		while (want_q.size() != 0 || r_ready) begin
			@(negedge clk);
		end
		// quiet window so a stray entry trips the reader
		repeat (SETTLE_CYCLES) @(negedge clk);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FIFO reader and timeout
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// one read every other cycle so r_ready is fresh for each strobe
	always @(posedge clk) begin
		if (!rst_n) begin
			r_enable <= 1'b0;
			read_issued <= 1'b0;
			data_read <= 1'b0;
		end else begin
			r_enable <= (ready_seen && !r_enable) || poke_empty;
			read_issued <= ready_seen && !r_enable;
			data_read <= r_enable && read_issued;
		end
	end

	always @(negedge clk) begin
		ready_seen = r_ready;
		if (data_read) begin
			if (want_q.size() == 0) begin
				stop_with_failure($sformatf(
					"rdata delivered entry 0x%04h although no entry was expected", rdata));
			end else begin
				want_entry = want_q.pop_front();
				check_entry(rdata, want_entry);
			end
		end
	end

	always @(posedge clk) begin
		if (timeout_limit > 0) begin
			cycles = cycles + 1;
			if (cycles >= timeout_limit) begin
				stop_with_failure($sformatf("run timed out after %0d clock cycles", cycles));
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		bclk_q = '0;
		lrclk_q = '0;
		sdata_q = '0;
		poke_empty = 1'b0;
		lr_state = '0;
		prev_lsb = '0;
		rand_seed = 32'h51fb5f2d;
		$readmemh("verification/i2s_capture_stimulus.txt", stim_mem);

		// sanity pass over the file that also sizes the timeout
		total_bits = 0;
		rec_idx = 0;
		while (stim_mem[rec_idx] !== END_MARK) begin
			cnt_at = count_index(rec_idx);
			if (int'(stim_mem[cnt_at]) % `PAYLOAD_BYTES != 0) begin
				stop_with_failure($sformatf(
					"stimulus record at word %0d expects a partial payload", rec_idx));
			end
			for (k = 1; k <= int'(stim_mem[cnt_at]); k++) begin
				file_entry = stim_mem[cnt_at + k];
				if (file_entry.id != `LANE0_ID && file_entry.id != `LANE1_ID) begin
					stop_with_failure($sformatf(
						"stimulus record at word %0d holds an unknown lane id", rec_idx));
				end
			end
			total_bits += lanes_of(rec_idx) * int'(stim_mem[rec_idx + 1]) / 2 * 24;
			rec_idx = next_record(rec_idx);
			if (rec_idx >= STIM_WORDS) begin
				stop_with_failure("stimulus file has no end marker");
			end
		end
		timeout_limit = total_bits * 8 * 2 + 2000;

		@(posedge clk);
		while (!rst_n) begin
			@(posedge clk);
		end

		rec_idx = 0;
		while (stim_mem[rec_idx] !== END_MARK) begin
			run_record(rec_idx);
			rec_idx = next_record(rec_idx);
		end

		// drained and no overflow so far
		@(negedge clk);
		check_flag("r_ready", r_ready, 1'b0);
		check_flag("error_full", error_full, 1'b0);
		check_flag("error_empty", error_empty, 1'b0);

		// single strobe into the empty FIFO
		@(posedge clk);
		poke_empty <= 1'b1;
		@(posedge clk);
		poke_empty <= 1'b0;
		repeat (3) @(negedge clk);
		check_flag("error_empty", error_empty, 1'b1);
		repeat (20) @(negedge clk);
		check_flag("error_empty", error_empty, 1'b1);
		check_flag("error_full", error_full, 1'b0);
		check_flag("r_ready", r_ready, 1'b0);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 5;

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire
